// File: verilog/exec_pkg.sv
/* shared types of the execute stage; the word width is fixed at 32 by the instruction set
   and the control and forwarding structs are packed, so their field order is the bit order */
`default_nettype none

package exec_pkg;

    localparam int word_w = 32;         // data path width

    typedef logic [word_w-1:0] word_t;

    // operations of all three units, decoded upstream
    typedef enum logic [4:0] {
        nop, pass_a, pass_b,
        add, sub, subu,
        op_or, op_and, op_xor, op_nor,
        slt, sltu,
        sll, srl, sra,
        mult, multu, divu,
        mfhi, mflo, mthi, mtlo
    } alu_op_e;

    // unused codes of operand a fall back to rs
    typedef enum logic [1:0] {muxa_rs = 2'd0, muxa_ext = 2'd1} muxa_sel_e;

    typedef enum logic [1:0] {muxb_rt = 2'd0, muxb_ext = 2'd1} muxb_sel_e;

    typedef enum logic [2:0] {none = 3'd0, from_alu = 3'd1, from_dmem = 3'd2} fwd_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;              // goes to every unit unchanged
        muxa_sel_e muxa_sel;
        muxb_sel_e muxb_sel;
        fwd_sel_e  a_fwd;               // forwarding onto rs
        fwd_sel_e  st_fwd;              // forwarding onto store data
    } exec_ctrl_t;

    // results of later stages, fed back
    typedef struct packed {
        word_t alu;                     // from memory stage input
        word_t dmem;                    // from write-back
    } fwd_data_t;

endpackage

`default_nettype wire

// File: verilog/operand_select.sv
/* operand b takes the unforwarded rt; forwarding applies to operand a and store data only */
`timescale 1ns/100ps
`default_nettype none

module operand_select (
    input  wire exec_pkg::exec_ctrl_t ctrl_i,
    input  wire exec_pkg::word_t      rs_i,
    input  wire exec_pkg::word_t      rt_i,
    input  wire exec_pkg::word_t      ext_i,
    input  wire exec_pkg::fwd_data_t  fwd_i,
    output exec_pkg::word_t           op_a_o,
    output exec_pkg::word_t           op_b_o,
    output exec_pkg::word_t           store_data_o
);

    import exec_pkg::*;

    word_t rs_fwd;

    // picks a later-stage result over the register file value
    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                      input fwd_data_t fwd);
        word_t val;
        case (sel)
            from_alu:  val = fwd.alu;
            from_dmem: val = fwd.dmem;
            default:   val = reg_val;   // none and unused codes
        endcase
        return val;
    endfunction

    assign rs_fwd       = fwd_mux(ctrl_i.a_fwd, rs_i, fwd_i);
    assign store_data_o = fwd_mux(ctrl_i.st_fwd, rt_i, fwd_i);

    always_comb
    begin
        case (ctrl_i.muxa_sel)
            muxa_ext: op_a_o = ext_i;
            default:  op_a_o = rs_fwd;
        endcase
    end

    assign op_b_o = (ctrl_i.muxb_sel == muxb_ext) ? ext_i : rt_i;  // no forwarding on b

endmodule

`default_nettype wire

// File: verilog/alu_logic.sv
/* no overflow trap: add and sub wrap like addu and subu */
`timescale 1ns/100ps
`default_nettype none

module alu_logic (
    input  wire exec_pkg::alu_op_e op_i,
    input  wire exec_pkg::word_t   a_i,
    input  wire exec_pkg::word_t   b_i,
    output exec_pkg::word_t        y_o
);

    import exec_pkg::*;

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb
    begin
        case (op_i)
            pass_a:
                y_o = a_i;
            pass_b:
                y_o = b_i;
            add:
                y_o = a_i + b_i;
            sub, subu:
                y_o = a_i - b_i;        // modulo 2^32 for both
            op_or:
                y_o = a_i | b_i;
            op_and:
                y_o = a_i & b_i;
            op_xor:
                y_o = a_i ^ b_i;
            op_nor:
                y_o = ~(a_i | b_i);
            slt:
                y_o = word_t'(lt_signed);
            sltu:
                y_o = word_t'(lt_unsigned);
            default:
                y_o = '0;               // shifter or muldiv op, keeps the result OR clean
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/barrel_shifter.sv
/* only amount_i[4:0] is used, upper bits are ignored; one right-shift network serves
   all three shifts, sll runs through it bit-reversed */
`timescale 1ns/100ps
`default_nettype none

module barrel_shifter (
    input  wire exec_pkg::alu_op_e op_i,
    input  wire exec_pkg::word_t   data_i,
    input  wire exec_pkg::word_t   amount_i,
    output exec_pkg::word_t        y_o
);

    import exec_pkg::*;

    function automatic word_t bit_rev(input word_t x);
        word_t r;
        for (int i = 0; i < word_w; i++)
            r[i] = x[word_w-1-i];
        return r;
    endfunction

    logic  fill;                        // bit shifted in from the left
    word_t stage;

    always_comb
    begin
        fill  = (op_i == sra) && data_i[word_w-1];
        stage = (op_i == sll) ? bit_rev(data_i) : data_i;
        for (int s = 0; s < 5; s++)     // 1, 2, 4, 8, 16
            if (amount_i[s])
                stage = (stage >> (1 << s)) | (fill ? ~('1 >> (1 << s)) : '0);
        case (op_i)
            sll:      y_o = bit_rev(stage);
            srl, sra: y_o = stage;
            default:  y_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/muldiv_unit.sv
/* busy for 33 cycles per mult/multu/divu; starts and mthi/mtlo are dropped while busy,
   mfhi/mflo keep reading the old hi/lo until the last cycle writes them */
`timescale 1ns/100ps
`default_nettype none

module muldiv_unit (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire exec_pkg::alu_op_e op_i,
    input  wire exec_pkg::word_t   a_i,
    input  wire exec_pkg::word_t   b_i,
    output exec_pkg::word_t        y_o,
    output logic                   busy_o
);

    import exec_pkg::*;

    typedef enum logic [1:0] {idle, run, finish} state_e;

    state_e      state;
    logic [4:0]  cnt;                   // iteration count
    logic [63:0] work;                  // partial product, or remainder:quotient
    word_t       opnd;                  // multiplicand magnitude or divisor
    logic        is_div;
    logic        neg;                   // signed product needs negation
    word_t       hi;
    word_t       lo;
    logic        start;
    logic        signed_op;
    word_t       a_mag;
    word_t       b_mag;
    logic [32:0] acc;
    logic [63:0] work_nxt;
    logic [63:0] product;

    assign start     = (op_i == mult) || (op_i == multu) || (op_i == divu);
    assign signed_op = (op_i == mult);
    assign a_mag     = (signed_op && a_i[31]) ? word_t'(-a_i) : a_i;
    assign b_mag     = (signed_op && b_i[31]) ? word_t'(-b_i) : b_i;

    // one iteration step, shift-add or restoring subtract
    always_comb
    begin
        if (is_div)
        begin
            acc = {work[63:32], work[31]} - {1'b0, opnd};
            if (acc[32])                // negative, restore
                work_nxt = {work[62:0], 1'b0};
            else
                work_nxt = {acc[31:0], work[30:0], 1'b1};
        end
        else
        begin
            acc      = {1'b0, work[63:32]} + (work[0] ? {1'b0, opnd} : 33'd0);
            work_nxt = {acc, work[31:1]};
        end
    end

    assign product = neg ? -work : work;   // neg is never set for divu

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state <= idle;
            cnt   <= '0;
            hi    <= '0;
            lo    <= '0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (start)
                    begin
                        state <= run;
                        cnt   <= '0;
                    end
                    else if (op_i == mthi)
                        hi <= a_i;
                    else if (op_i == mtlo)
                        lo <= a_i;
                end
                run:
                begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'd31)
                        state <= finish;
                end
                finish:
                begin
                    hi    <= product[63:32];  // remainder for divu
                    lo    <= product[31:0];   // quotient for divu
                    state <= idle;
                end
                default:
                    state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == idle && start)
        begin
            work   <= {32'd0, a_mag};
            opnd   <= b_mag;
            is_div <= (op_i == divu);
            neg    <= signed_op && (a_i[31] ^ b_i[31]);
        end
        else if (state == run)
            work <= work_nxt;
    end

    assign busy_o = (state != idle);
    assign y_o    = (op_i == mfhi) ? hi : (op_i == mflo) ? lo : '0;

endmodule

`default_nettype wire

// File: verilog/exec_stage.sv
/* no back-pressure: upstream must hold off muldiv ops while busy_o is high;
   each unit drives zero for ops it does not own, so the result is a plain OR */
`timescale 1ns/100ps
`default_nettype none

module exec_stage (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire exec_pkg::exec_ctrl_t ctrl_i,
    input  wire exec_pkg::word_t      rs_i,
    input  wire exec_pkg::word_t      rt_i,
    input  wire exec_pkg::word_t      ext_i,
    input  wire exec_pkg::fwd_data_t  fwd_i,
    output exec_pkg::word_t           result_o,
    output exec_pkg::word_t           store_data_o,
    output logic                      busy_o
);

    import exec_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_y;
    word_t shift_y;
    word_t md_y;                        // mfhi/mflo read-out

    operand_select u_operand_select (
        .ctrl_i       (ctrl_i),
        .rs_i         (rs_i),
        .rt_i         (rt_i),
        .ext_i        (ext_i),
        .fwd_i        (fwd_i),
        .op_a_o       (op_a),
        .op_b_o       (op_b),
        .store_data_o (store_data_o)
    );

    alu_logic u_alu_logic (
        .op_i (ctrl_i.alu_op),
        .a_i  (op_a),
        .b_i  (op_b),
        .y_o  (alu_y)
    );

    // b is the value, a supplies the amount
    barrel_shifter u_barrel_shifter (
        .op_i     (ctrl_i.alu_op),
        .data_i   (op_b),
        .amount_i (op_a),
        .y_o      (shift_y)
    );

    muldiv_unit u_muldiv_unit (
        .clk    (clk),
        .rst    (rst),
        .op_i   (ctrl_i.alu_op),
        .a_i    (op_a),
        .b_i    (op_b),
        .y_o    (md_y),
        .busy_o (busy_o)
    );

    assign result_o = alu_y | shift_y | md_y;

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
/* 8 ns clock; active-low reset held for 8 cycles, released on a falling edge */
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    localparam int half_period  = 4;
    localparam int reset_cycles = 8;

    initial
    begin
        clk_o = 1'b0;
        forever
            #half_period clk_o = ~clk_o;
    end

    initial
    begin
        rst_o = 1'b0;
        repeat (reset_cycles) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/exec_stage_tb.sv
/* inputs change on the falling edge and are sampled one falling edge later;
   the hi/lo moves run first so that they see the reset state */
`timescale 1ns/100ps
`default_nettype none

module exec_stage_tb;

    import exec_pkg::*;

    localparam int timeout_cycles = 3000;  // tests take about 1200 cycles

    logic        clk;
    logic        rst;
    exec_ctrl_t  ctrl;
    word_t       rs, rt, ext;
    fwd_data_t   fwd;
    word_t       result, store_data;
    logic        busy;
    logic [31:0] lfsr_state;
    word_t       model_hi;                // hi as the tests expect it
    int          cycle_count = 0;

    tb_clock u_clock (.clk_o(clk), .rst_o(rst));

    exec_stage uut (
        .clk          (clk),
        .rst          (rst),
        .ctrl_i       (ctrl),
        .rs_i         (rs),
        .rt_i         (rt),
        .ext_i        (ext),
        .fwd_i        (fwd),
        .result_o     (result),
        .store_data_o (store_data),
        .busy_o       (busy)
    );

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("run timed out after %0d cycles before the tests finished", cycle_count);
            $display("Checks failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output word_t w);
        w = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    function automatic exec_ctrl_t make_ctrl(input alu_op_e op, input muxa_sel_e ma,
                                             input muxb_sel_e mb, input fwd_sel_e af,
                                             input fwd_sel_e sf);
        exec_ctrl_t c;
        c.alu_op   = op;
        c.muxa_sel = ma;
        c.muxb_sel = mb;
        c.a_fwd    = af;
        c.st_fwd   = sf;
        return c;
    endfunction

    task automatic drive_ops(input alu_op_e op, input word_t a, input word_t b);
        ctrl = make_ctrl(op, muxa_rs, muxb_rt, none, none);
        rs   = a;
        rt   = b;
    endtask

    task automatic run_comb(input string name, input alu_op_e op, input word_t a,
                            input word_t b, input word_t expected);
        drive_ops(op, a, b);
        @(negedge clk);
        check_value(name, expected, result);
    endtask

    task automatic select_case(input string name, input exec_ctrl_t c,
                               input word_t exp_result, input word_t exp_store);
        ctrl = c;
        @(negedge clk);
        check_value(name, exp_result, result);
        check_value({name, " store"}, exp_store, store_data);
    endtask

    // start, count busy cycles while reading the old hi, then read the new hi/lo
    task automatic long_op(input string name, input alu_op_e op, input word_t a,
                           input word_t b, input word_t exp_hi, input word_t exp_lo);
        int busy_cycles;
        drive_ops(op, a, b);
        @(negedge clk);
        check_value({name, " busy after start"}, 32'd1, {31'd0, busy});
        drive_ops(mfhi, '0, '0);
        busy_cycles = 1;
        @(negedge clk);
        while (busy)
        begin
            check_value({name, " old hi while busy"}, model_hi, result);
            busy_cycles++;
            @(negedge clk);
        end
        check_value({name, " busy cycles"}, 33, busy_cycles);
        run_comb({name, " lo"}, mflo, '0, '0, exp_lo);
        run_comb({name, " hi"}, mfhi, '0, '0, exp_hi);
        model_hi = exp_hi;
    endtask

    task automatic moves_after_reset();
        word_t v_hi, v_lo;
        check_value("reset busy", '0, {31'd0, busy});
        run_comb("reset hi", mfhi, '0, '0, '0);
        run_comb("reset lo", mflo, '0, '0, '0);
        random_bits(32, v_hi);
        random_bits(32, v_lo);
        drive_ops(mthi, v_hi, '0);      // value travels on rs
        @(negedge clk);
        drive_ops(mtlo, v_lo, '0);
        @(negedge clk);
        run_comb("mthi read back", mfhi, '0, '0, v_hi);
        run_comb("mtlo read back", mflo, '0, '0, v_lo);
        model_hi = v_hi;
    endtask

    task automatic alu_ops();
        word_t a, b;
        for (int i = 0; i < 20; i++)
        begin
            random_bits(32, a);
            random_bits(32, b);
            run_comb("add", add, a, b, a + b);
            run_comb("sub", sub, a, b, a - b);
            run_comb("subu", subu, a, b, a - b);
            run_comb("or", op_or, a, b, a | b);
            run_comb("and", op_and, a, b, a & b);
            run_comb("xor", op_xor, a, b, a ^ b);
            run_comb("nor", op_nor, a, b, ~(a | b));
            run_comb("slt", slt, a, b, {31'd0, $signed(a) < $signed(b)});
            run_comb("sltu", sltu, a, b, {31'd0, a < b});
            run_comb("pass_a", pass_a, a, b, a);
            run_comb("pass_b", pass_b, a, b, b);
        end
    endtask

    // amount on rs with random upper bits, data on rt
    task automatic shift_ops();
        word_t data, amount;
        for (int i = 0; i < 22; i++)
        begin
            random_bits(32, data);
            random_bits(32, amount);
            if (i == 0)
                amount[4:0] = 5'd0;
            if (i == 1)
            begin
                data[31]    = 1'b1;     // negative value, widest shift
                amount[4:0] = 5'd31;
            end
            run_comb("sll", sll, amount, data, data << amount[4:0]);
            run_comb("srl", srl, amount, data, data >> amount[4:0]);
            run_comb("sra", sra, amount, data, $signed(data) >>> amount[4:0]);
        end
    endtask

    task automatic operand_paths();
        random_bits(32, rs);
        random_bits(32, rt);
        random_bits(32, ext);
        random_bits(32, fwd.alu);
        random_bits(32, fwd.dmem);
        select_case("a from alu", make_ctrl(pass_a, muxa_rs, muxb_rt, from_alu, none),
                    fwd.alu, rt);
        select_case("a from dmem", make_ctrl(pass_a, muxa_rs, muxb_rt, from_dmem, none),
                    fwd.dmem, rt);
        select_case("a from ext", make_ctrl(pass_a, muxa_ext, muxb_rt, from_alu, none),
                    ext, rt);
        select_case("b from ext", make_ctrl(pass_b, muxa_rs, muxb_ext, none, from_alu),
                    ext, fwd.alu);
        select_case("b unforwarded", make_ctrl(pass_b, muxa_rs, muxb_rt, from_alu, from_dmem),
                    rt, fwd.dmem);
        select_case("add fwd ext", make_ctrl(add, muxa_rs, muxb_ext, from_dmem, none),
                    fwd.dmem + ext, rt);
    endtask

    task automatic multiply_ops();
        word_t a, b;
        logic [63:0] p;
        for (int i = 0; i < 7; i++)
        begin
            random_bits(32, a);
            random_bits(32, b);
            if (i == 6)
            begin
                a = 32'hffff_ffff;      // -1 times the most negative value
                b = 32'h8000_0000;
            end
            p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
            long_op("mult", mult, a, b, p[63:32], p[31:0]);
            p = {32'd0, a} * {32'd0, b};
            long_op("multu", multu, a, b, p[63:32], p[31:0]);
        end
    endtask

    task automatic divide_ops();
        word_t a, b;
        for (int i = 0; i < 8; i++)
        begin
            random_bits(32, a);
            random_bits((i < 4) ? 32 : 12, b);  // short divisors give large quotients
            if (b == '0)
                b = 32'd1;
            long_op("divu", divu, a, b, a % b, a / b);
        end
        long_op("divu by zero", divu, a, '0, a, 32'hffff_ffff);
    endtask

    initial
    begin
        ctrl       = make_ctrl(nop, muxa_rs, muxb_rt, none, none);
        rs         = '0;
        rt         = '0;
        ext        = '0;
        fwd        = '0;
        lfsr_state = 32'd46;
        model_hi   = '0;
        wait (rst === 1'b1);
        @(negedge clk);
        moves_after_reset();
        alu_ops();
        shift_ops();
        operand_paths();
        multiply_ops();
        divide_ops();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
verilog/exec_pkg.sv
verilog/operand_select.sv
verilog/alu_logic.sv
verilog/barrel_shifter.sv
verilog/muldiv_unit.sv
verilog/exec_stage.sv
tests/tb_clock.sv
tests/exec_stage_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = exec_stage_tb
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
